// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_uart
FLIST    ?= list.f
BUILD    ?= obj_dir
LOG      ?= sim.log
PASS_MSG  = Simulation PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run $(TOP), result from $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== list.f ====
uart_pkg.sv
uart_csr.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
uart_properties.sv
tb_uart.sv

// ==== tb_uart.sv ====
/* UART testbench: clock, reset, LFSR stimulus, register bus tasks,
   serial driver and decoder, frame reference, compare process, timeout */

`timescale 1ns/1ps
`default_nettype none

module tb_uart;

   import uart_pkg::*;

   localparam int BIT_DIV     = 16;
   localparam int TEST_FRAMES = 24;                 // all six tests incl. idle gaps
   localparam int LIMIT       = 3 * TEST_FRAMES * FRAME_BITS * BIT_DIV + 1000;

   logic        clk_i = 1'b0;
   logic        arst_i;
   logic        csr_we_i;
   logic        csr_re_i;
   logic [2:0]  csr_addr_i;
   logic [15:0] csr_wdata_i;
   logic [15:0] csr_rdata_o;
   logic        rxd_i;
   logic        txd_o;
   logic        cts_i;
   logic        rts_o;

   logic [31:0] lfsr = 32'he32f;
   int          cycles = 0;
   int          checks = 0;
   int          errors = 0;
   int          err_mark = 0;
   logic [15:0] got_q[$];
   logic [15:0] exp_q[$];
   string       what_q[$];
   event        result_ev;

   uart_top #(.DIV_W(16)) u_dut (
      .clk_i(clk_i), .arst_i(arst_i),
      .csr_we_i(csr_we_i), .csr_re_i(csr_re_i), .csr_addr_i(csr_addr_i),
      .csr_wdata_i(csr_wdata_i), .csr_rdata_o(csr_rdata_o),
      .rxd_i(rxd_i), .txd_o(txd_o), .cts_i(cts_i), .rts_o(rts_o)
   );

   initial begin
      forever #5 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles == LIMIT) begin
         $display("timeout: tests still running after %0d cycles", cycles);
         $display("Simulation FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // reference and stimulus helpers
   ////////////////////////////////////////////////////////////////////////////

   // line order: start 0, data lsb first, stop 1
   function automatic logic [FRAME_BITS-1:0] frame_of(input logic [7:0] data);
      logic [FRAME_BITS-1:0] f;
      f[0] = 1'b0;
      for (int i = 0; i < DATA_BITS; i++) begin
         f[i + 1] = data[i];
      end
      f[FRAME_BITS-1] = 1'b1;
      return f;
   endfunction

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
   endfunction

   task automatic rand_byte(output logic [7:0] data);
      for (int i = 0; i < DATA_BITS; i++) begin
         lfsr    = lfsr_step(lfsr);
         data[i] = lfsr[0];
      end
   endtask

   task automatic queue_check(input logic [15:0] got, input logic [15:0] exp,
                              input string what);
      got_q.push_back(got);
      exp_q.push_back(exp);
      what_q.push_back(what);
      -> result_ev;
   endtask

   // all bus tasks start and end on a falling edge
   task automatic reg_write(input uart_addr_e addr, input logic [15:0] data);
      csr_we_i    = 1'b1;
      csr_addr_i  = addr;
      csr_wdata_i = data;
      @(negedge clk_i);
      csr_we_i    = 1'b0;
   endtask

   task automatic reg_read(input uart_addr_e addr, output logic [15:0] data);
      csr_re_i   = 1'b1;
      csr_addr_i = addr;
      @(negedge clk_i);
      csr_re_i   = 1'b0;
      data       = csr_rdata_o;                      // registered, stable here
   endtask

   task automatic wait_ready(input uart_addr_e addr);
      logic [15:0] v;
      v = '0;
      while (v[0] !== 1'b1) reg_read(addr, v);
   endtask

   task automatic drive_frame(input logic [7:0] data);
      logic [FRAME_BITS-1:0] f;
      f     = frame_of(data);
      rxd_i = 1'b1;
      repeat (2 * BIT_DIV) @(negedge clk_i);         // idle gap
      for (int i = 0; i < FRAME_BITS; i++) begin
         rxd_i = f[i];
         repeat (BIT_DIV) @(negedge clk_i);
      end
   endtask

   task automatic decode_frame(output logic [FRAME_BITS-1:0] f);
      @(negedge txd_o);
      repeat (BIT_DIV / 2) @(posedge clk_i);
      @(negedge clk_i);                              // middle of start bit
      f[0] = txd_o;
      for (int i = 1; i < FRAME_BITS; i++) begin
         repeat (BIT_DIV) @(negedge clk_i);
         f[i] = txd_o;
      end
   endtask

   task automatic end_test(input string name);
      @(negedge clk_i);
      $display("%-12s done, %0d errors", name, errors - err_mark);
      err_mark = errors;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // compare process
   ////////////////////////////////////////////////////////////////////////////

   initial begin : compare
      logic [15:0] got;
      logic [15:0] exp;
      string       what;
      forever begin
         @(result_ev);
         while (got_q.size() > 0) begin
            got  = got_q.pop_front();
            exp  = exp_q.pop_front();
            what = what_q.pop_front();
            checks++;
            assert (got === exp) else begin
               $display("FAIL at %0t ns: %s, got %h expected %h", $time, what, got, exp);
               errors++;
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // tests
   ////////////////////////////////////////////////////////////////////////////

   initial begin : main
      logic [15:0]           v;
      logic [7:0]            b;
      logic [FRAME_BITS-1:0] f;
      logic                  seen_low;
      arst_i      = 1'b0;
      csr_we_i    = 1'b0;
      csr_re_i    = 1'b0;
      csr_addr_i  = '0;
      csr_wdata_i = '0;
      rxd_i       = 1'b1;
      cts_i       = 1'b1;
      repeat (3) @(negedge clk_i);
      arst_i = 1'b1;

      queue_check(16'(txd_o), 16'd1, "txd_o after reset");
      queue_check(16'(rts_o), 16'd0, "rts_o after reset");
      reg_read(TX_READY, v);
      queue_check(v, 16'd0, "tx ready after reset");
      reg_read(RX_READY, v);
      queue_check(v, 16'd0, "rx ready after reset");
      end_test("reset");

      reg_write(DIV, 16'(BIT_DIV));
      reg_write(TX_EN, 16'd1);
      for (int n = 0; n < 8; n++) begin
         rand_byte(b);
         wait_ready(TX_READY);
         reg_write(TX_DATA, 16'(b));
         decode_frame(f);
         queue_check(16'(f), 16'(frame_of(b)), "transmitted frame");
      end
      end_test("transmit");

      reg_write(RX_EN, 16'd1);
      queue_check(16'(rts_o), 16'd1, "rts_o with receiver on");
      for (int n = 0; n < 8; n++) begin
         rand_byte(b);
         drive_frame(b);
         wait_ready(RX_READY);
         reg_read(RX_DATA, v);
         queue_check(v, 16'(b), "received byte");
         reg_read(RX_READY, v);
         queue_check(v, 16'd0, "rx ready after data read");
      end
      end_test("receive");

      wait_ready(TX_READY);
      cts_i = 1'b0;
      repeat (3) @(negedge clk_i);                   // past the synchronizer
      reg_read(TX_READY, v);
      queue_check(v, 16'd0, "tx ready with cts low");
      reg_write(TX_DATA, 16'h0000);                  // held off, starts nothing
      seen_low = 1'b0;
      repeat (3 * FRAME_BITS * BIT_DIV) begin
         @(negedge clk_i);
         if (!txd_o) seen_low = 1'b1;
      end
      queue_check(16'(seen_low), 16'd0, "txd_o low while cts low");
      cts_i = 1'b1;
      rand_byte(b);
      wait_ready(TX_READY);
      reg_write(TX_DATA, 16'(b));
      decode_frame(f);
      queue_check(16'(f), 16'(frame_of(b)), "frame after cts release");
      end_test("flow");

      rxd_i = 1'b0;
      repeat (BIT_DIV / 2 - 4) @(negedge clk_i);    // well short of mid start bit
      rxd_i = 1'b1;
      repeat ((FRAME_BITS + 2) * BIT_DIV) @(negedge clk_i);   // longer than a whole frame
      reg_read(RX_READY, v);
      queue_check(v, 16'd0, "rx ready after glitch");
      rand_byte(b);
      drive_frame(b);
      wait_ready(RX_READY);
      reg_read(RX_DATA, v);
      queue_check(v, 16'(b), "byte after glitch");
      end_test("false start");

      // all-zero byte keeps the line low mid-frame
      wait_ready(TX_READY);
      reg_write(TX_DATA, 16'h0000);
      @(negedge txd_o);
      @(negedge clk_i);
      repeat (3 * BIT_DIV) @(negedge clk_i);
      queue_check(16'(txd_o), 16'd0, "txd_o mid-frame");
      reg_write(SOFT_RESET, 16'd0);
      @(negedge clk_i);
      queue_check(16'(txd_o), 16'd1, "txd_o after soft reset");
      queue_check(16'(rts_o), 16'd0, "rts_o after soft reset");
      reg_read(TX_EN, v);
      queue_check(v, 16'd0, "tx enable after soft reset");
      reg_read(RX_EN, v);
      queue_check(v, 16'd0, "rx enable after soft reset");
      reg_read(DIV, v);
      queue_check(v, 16'(BIT_DIV), "bit duration after soft reset");
      end_test("soft reset");

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== uart_csr.sv ====
/* register file: write decode, bit duration, enables, transmit byte,
   soft reset pulse and registered read data */

`timescale 1ns/1ps
`default_nettype none

module uart_csr #(
   parameter int unsigned DIV_W = 16
) (
   input  logic                           clk_i,
   input  logic                           arst_i,
   // host register bus
   input  logic                           csr_we_i,
   input  logic                           csr_re_i,
   input  logic [uart_pkg::ADDR_W-1:0]    csr_addr_i,
   input  logic [DIV_W-1:0]               csr_wdata_i,
   output logic [DIV_W-1:0]               csr_rdata_o,
   // controller status
   input  logic                           tx_ready_i,
   input  logic                           rx_ready_i,
   input  logic [uart_pkg::DATA_BITS-1:0] rx_byte_i,
   // controller configuration
   output logic [DIV_W-1:0]               bit_div_o,
   output logic                           tx_en_o,
   output logic                           rx_en_o,
   output logic                           soft_rst_o,
   output logic [uart_pkg::DATA_BITS-1:0] tx_byte_o,
   output logic                           tx_start_o,
   output logic                           rx_taken_o
);

   import uart_pkg::*;

   uart_addr_e addr;

   assign addr = uart_addr_e'(csr_addr_i);

   // strobes go straight to the controllers so they act on the write edge
   assign tx_start_o = csr_we_i && (addr == TX_DATA);
   assign rx_taken_o = csr_re_i && (addr == RX_DATA);

   ////////////////////////////////////////////////////////////////////////////
   // write side
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         bit_div_o  <= '0;
         tx_en_o    <= 1'b0;
         rx_en_o    <= 1'b0;
         soft_rst_o <= 1'b0;
      end else begin
         soft_rst_o <= 1'b0;                      // single cycle pulse
         if (csr_we_i) begin
            case (addr)
               SOFT_RESET: begin
                  soft_rst_o <= 1'b1;
                  tx_en_o    <= 1'b0;             // bit_div survives
                  rx_en_o    <= 1'b0;
               end
               DIV:     bit_div_o <= csr_wdata_i;
               TX_EN:   tx_en_o   <= csr_wdata_i[0];
               RX_EN:   rx_en_o   <= csr_wdata_i[0];
               default: ;                         // read only or pulse only
            endcase
         end
      end
   end

   // byte to send, picked up by the transmitter in TX_LOAD
   always_ff @(posedge clk_i) begin
      if (tx_start_o) begin
         tx_byte_o <= csr_wdata_i[DATA_BITS-1:0];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // read side
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         csr_rdata_o <= '0;
      end else if (csr_re_i) begin                // holds until the next read
         case (addr)
            DIV:      csr_rdata_o <= bit_div_o;
            TX_EN:    csr_rdata_o <= DIV_W'(tx_en_o);
            RX_EN:    csr_rdata_o <= DIV_W'(rx_en_o);
            TX_READY: csr_rdata_o <= DIV_W'(tx_ready_i);
            RX_READY: csr_rdata_o <= DIV_W'(rx_ready_i);
            RX_DATA:  csr_rdata_o <= DIV_W'(rx_byte_i);
            default:  csr_rdata_o <= '0;          // write only registers
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== uart_pkg.sv ====
/* register address map, transmit and receive FSM state encodings,
   serial frame constants */

`default_nettype none

package uart_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // frame layout
   ////////////////////////////////////////////////////////////////////////////

   localparam int unsigned DATA_BITS  = 8;               // payload, lsb first
   localparam int unsigned FRAME_BITS = DATA_BITS + 2;   // start + data + stop

   localparam int unsigned ADDR_W = 3;                   // register bus address

   ////////////////////////////////////////////////////////////////////////////
   // register map
   ////////////////////////////////////////////////////////////////////////////

   typedef enum logic [ADDR_W-1:0] {
      SOFT_RESET = 3'd0,   // write only, pulses controller reset
      DIV        = 3'd1,   // cycles per serial bit
      TX_DATA    = 3'd2,   // byte to send
      TX_EN      = 3'd3,
      RX_EN      = 3'd4,
      TX_READY   = 3'd5,   // read only
      RX_READY   = 3'd6,   // read only
      RX_DATA    = 3'd7    // read only, read clears rx ready
   } uart_addr_e;

   ////////////////////////////////////////////////////////////////////////////
   // controller states
   ////////////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      TX_IDLE,   // waiting for a byte
      TX_LOAD,   // build the frame pattern
      TX_SEND    // shift the pattern out
   } tx_state_e;

   typedef enum logic [2:0] {
      RX_SYNC,         // wait for the line to go high
      RX_IDLE_CHECK,   // line must stay high one bit time
      RX_WAIT_START,
      RX_START,        // check the start bit at its middle
      RX_BITS          // data bits, then the stop bit
   } rx_state_e;

endpackage

`default_nettype wire

// ==== uart_properties.sv ====
/* concurrent checks on the UART top-level pins, bound into uart_top */

`timescale 1ns/1ps
`default_nettype none

module uart_properties (
   input  logic                        clk_i,
   input  logic                        arst_i,
   input  logic                        txd_i,
   input  logic                        rts_i,
   input  logic                        wdata_lsb_i,
   input  logic                        tx_ready_i,
   input  logic                        csr_we_i,
   input  logic [uart_pkg::ADDR_W-1:0] csr_addr_i,
   input  uart_pkg::tx_state_e         tx_state_i
);

   import uart_pkg::*;

   // idle transmitter keeps the line at mark level
   a_txd_idle: assert property (@(posedge clk_i) disable iff (!arst_i)
      (tx_state_i == TX_IDLE) |-> txd_i)
      else $error("txd_o low while transmitter idle");

   // host turns the receiver off, rts follows on the next edge
   a_rts_off: assert property (@(posedge clk_i) disable iff (!arst_i)
      (csr_we_i && (((csr_addr_i == RX_EN) && !wdata_lsb_i) || (csr_addr_i == SOFT_RESET)))
      |=> !rts_i)
      else $error("rts_o high with receiver disabled");

   // only an RX_EN write can raise rts
   a_rts_hold: assert property (@(posedge clk_i) disable iff (!arst_i)
      (!rts_i && !(csr_we_i && (csr_addr_i == RX_EN))) |=> !rts_i)
      else $error("rts_o rose without the receiver being enabled");

   a_ready_drop: assert property (@(posedge clk_i) disable iff (!arst_i)
      (csr_we_i && (csr_addr_i == TX_DATA) && tx_ready_i) |=> !tx_ready_i)
      else $error("tx ready still high after byte write");

endmodule

bind uart_top uart_properties u_props (
   .clk_i      (clk_i),
   .arst_i     (arst_i),
   .txd_i      (txd_o),
   .rts_i      (rts_o),
   .wdata_lsb_i(csr_wdata_i[0]),
   .tx_ready_i (tx_ready),
   .csr_we_i   (csr_we_i),
   .csr_addr_i (csr_addr_i),
   .tx_state_i (u_tx.state)
);

`default_nettype wire

// ==== uart_rx.sv ====
/* receive controller: line synchronizer, idle check, mid-bit sampling,
   received byte register and request-to-send */

`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
   parameter int unsigned DIV_W = 16
) (
   input  logic                           clk_i,
   input  logic                           arst_i,
   input  logic                           soft_rst_i,
   input  logic                           rx_en_i,
   input  logic                           rxd_i,
   input  logic [DIV_W-1:0]               bit_div_i,
   input  logic                           rx_taken_i,
   output logic [uart_pkg::DATA_BITS-1:0] rx_byte_o,
   output logic                           rx_ready_o,
   output logic                           rts_o
);

   import uart_pkg::*;

   localparam int unsigned CNT_W = $clog2(DATA_BITS + 1);

   logic [1:0]           rxd_sync;
   logic                 rxd_s;
   logic                 active;
   logic                 sample_tick;
   rx_state_e            state;
   logic [DIV_W-1:0]     cyc_cnt;
   logic [CNT_W-1:0]     bit_cnt;
   logic [DATA_BITS-1:0] shift;

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         rxd_sync <= 2'b11;                      // idle line level
      end else begin
         rxd_sync <= {rxd_sync[0], rxd_i};
      end
   end

   assign rxd_s       = rxd_sync[1];
   assign active      = rx_en_i && !soft_rst_i;
   assign rts_o       = rx_en_i;                 // ready to take frames
   assign sample_tick = active && (state == RX_BITS) && (cyc_cnt == bit_div_i);

   ////////////////////////////////////////////////////////////////////////////
   // frame FSM
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         state      <= RX_SYNC;
         cyc_cnt    <= DIV_W'(1);
         bit_cnt    <= '0;
         rx_ready_o <= 1'b0;
      end else if (!active) begin
         state      <= RX_SYNC;
         cyc_cnt    <= DIV_W'(1);
         bit_cnt    <= '0;
         rx_ready_o <= 1'b0;
      end else begin
         if (rx_taken_i) rx_ready_o <= 1'b0;     // a new byte below wins
         case (state)
            RX_SYNC: begin
               cyc_cnt <= DIV_W'(1);
               bit_cnt <= '0;
               if (rxd_s) state <= RX_IDLE_CHECK;
            end
            RX_IDLE_CHECK: begin
               if (!rxd_s) begin
                  state <= RX_SYNC;              // line dropped too early
               end else if (cyc_cnt == bit_div_i) begin
                  state <= RX_WAIT_START;
               end else begin
                  cyc_cnt <= cyc_cnt + DIV_W'(1);
               end
            end
            RX_WAIT_START: begin
               cyc_cnt <= DIV_W'(1);
               bit_cnt <= '0;
               if (!rxd_s) state <= RX_START;
            end
            RX_START: begin
               if (cyc_cnt == (bit_div_i >> 1)) begin
                  cyc_cnt <= DIV_W'(1);
                  // high at mid start bit means a glitch
                  state   <= rxd_s ? RX_SYNC : RX_BITS;
               end else begin
                  cyc_cnt <= cyc_cnt + DIV_W'(1);
               end
            end
            RX_BITS: begin
               if (cyc_cnt == bit_div_i) begin
                  cyc_cnt <= DIV_W'(1);
                  if (bit_cnt == CNT_W'(DATA_BITS)) begin
                     rx_ready_o <= 1'b1;         // stop bit sampled
                     bit_cnt    <= '0;
                     state      <= rxd_s ? RX_WAIT_START : RX_SYNC;
                  end else begin
                     bit_cnt <= bit_cnt + CNT_W'(1);
                  end
               end else begin
                  cyc_cnt <= cyc_cnt + DIV_W'(1);
               end
            end
            default: state <= RX_SYNC;
         endcase
      end
   end

   // data path, lsb arrives first
   always_ff @(posedge clk_i) begin
      if (sample_tick) begin
         if (bit_cnt == CNT_W'(DATA_BITS)) begin
            rx_byte_o <= shift;
         end else begin
            shift <= {rxd_s, shift[DATA_BITS-1:1]};
         end
      end
   end

endmodule

`default_nettype wire

// ==== uart_top.sv ====
/* UART subsystem: register file plus transmit and receive controllers */

`timescale 1ns/1ps
`default_nettype none

module uart_top #(
   parameter int unsigned DIV_W = 16
) (
   input  logic                        clk_i,
   input  logic                        arst_i,
   // host register bus
   input  logic                        csr_we_i,
   input  logic                        csr_re_i,
   input  logic [uart_pkg::ADDR_W-1:0] csr_addr_i,
   input  logic [DIV_W-1:0]            csr_wdata_i,
   output logic [DIV_W-1:0]            csr_rdata_o,
   // serial pins
   input  logic                        rxd_i,
   output logic                        txd_o,
   input  logic                        cts_i,
   output logic                        rts_o
);

   import uart_pkg::*;

   logic [DIV_W-1:0]     bit_div;
   logic                 tx_en;
   logic                 rx_en;
   logic                 soft_rst;
   logic [DATA_BITS-1:0] tx_byte;
   logic                 tx_start;
   logic                 tx_ready;
   logic                 rx_taken;
   logic [DATA_BITS-1:0] rx_byte;
   logic                 rx_ready;

   uart_csr #(
      .DIV_W(DIV_W)
   ) u_csr (
      .clk_i      (clk_i),
      .arst_i     (arst_i),
      .csr_we_i   (csr_we_i),
      .csr_re_i   (csr_re_i),
      .csr_addr_i (csr_addr_i),
      .csr_wdata_i(csr_wdata_i),
      .csr_rdata_o(csr_rdata_o),
      .tx_ready_i (tx_ready),
      .rx_ready_i (rx_ready),
      .rx_byte_i  (rx_byte),
      .bit_div_o  (bit_div),
      .tx_en_o    (tx_en),
      .rx_en_o    (rx_en),
      .soft_rst_o (soft_rst),
      .tx_byte_o  (tx_byte),
      .tx_start_o (tx_start),
      .rx_taken_o (rx_taken)
   );

   uart_tx #(
      .DIV_W(DIV_W)
   ) u_tx (
      .clk_i     (clk_i),
      .arst_i    (arst_i),
      .soft_rst_i(soft_rst),
      .tx_en_i   (tx_en),
      .cts_i     (cts_i),
      .bit_div_i (bit_div),
      .tx_byte_i (tx_byte),
      .tx_start_i(tx_start),
      .tx_ready_o(tx_ready),
      .txd_o     (txd_o)
   );

   uart_rx #(
      .DIV_W(DIV_W)
   ) u_rx (
      .clk_i     (clk_i),
      .arst_i    (arst_i),
      .soft_rst_i(soft_rst),
      .rx_en_i   (rx_en),
      .rxd_i     (rxd_i),
      .bit_div_i (bit_div),
      .rx_taken_i(rx_taken),
      .rx_byte_o (rx_byte),
      .rx_ready_o(rx_ready),
      .rts_o     (rts_o)
   );

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
/* transmit controller: cts synchronizer, frame shifter, bit-time counter */

`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
   parameter int unsigned DIV_W = 16
) (
   input  logic                           clk_i,
   input  logic                           arst_i,
   input  logic                           soft_rst_i,
   input  logic                           tx_en_i,
   input  logic                           cts_i,
   input  logic [DIV_W-1:0]               bit_div_i,
   input  logic [uart_pkg::DATA_BITS-1:0] tx_byte_i,
   input  logic                           tx_start_i,
   output logic                           tx_ready_o,
   output logic                           txd_o
);

   import uart_pkg::*;

   localparam int unsigned CNT_W = $clog2(FRAME_BITS);

   logic [1:0]            cts_sync;
   logic                  allowed;
   tx_state_e             state;
   logic [FRAME_BITS-1:0] pattern;     // {stop, data, start}, lsb on the line
   logic [CNT_W-1:0]      bit_cnt;
   logic [DIV_W-1:0]      cyc_cnt;

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         cts_sync <= 2'b00;
      end else begin
         cts_sync <= {cts_sync[0], cts_i};
      end
   end

   assign allowed    = tx_en_i && cts_sync[1];
   assign tx_ready_o = (state == TX_IDLE) && allowed;
   assign txd_o      = pattern[0];

   ////////////////////////////////////////////////////////////////////////////
   // frame FSM
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         state   <= TX_IDLE;
         pattern <= '1;
         bit_cnt <= '0;
         cyc_cnt <= '0;
      end else if (soft_rst_i || !allowed) begin
         state   <= TX_IDLE;                    // back-pressure, line idles high
         pattern <= '1;
         bit_cnt <= '0;
         cyc_cnt <= '0;
      end else begin
         case (state)
            TX_IDLE: begin
               pattern <= '1;
               if (tx_start_i) state <= TX_LOAD;
            end
            TX_LOAD: begin
               pattern <= {1'b1, tx_byte_i, 1'b0};
               bit_cnt <= '0;
               cyc_cnt <= DIV_W'(1);
               state   <= TX_SEND;
            end
            TX_SEND: begin
               if (cyc_cnt == bit_div_i) begin
                  cyc_cnt <= DIV_W'(1);
                  if (bit_cnt == CNT_W'(FRAME_BITS - 1)) begin
                     pattern <= '1;             // stop bit done
                     state   <= TX_IDLE;
                  end else begin
                     pattern <= {1'b1, pattern[FRAME_BITS-1:1]};
                     bit_cnt <= bit_cnt + CNT_W'(1);
                  end
               end else begin
                  cyc_cnt <= cyc_cnt + DIV_W'(1);
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire
